// File: axis_debug.f
+incdir+rtl
rtl/cmd_pkg.sv
rtl/chan_pkg.sv
rtl/cmd_regs.sv
rtl/stream_governor.sv
rtl/log_arbiter.sv
rtl/axis_debug_top.sv
tb/tb_axis_debug.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f axis_debug.f --top-module tb_axis_debug \
    --Mdir obj_dir -o sim_axis_debug
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_axis_debug)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: tb/tb_axis_debug.sv
`timescale 1ns/10ps
`include "dbg_defs.svh"

module tb_axis_debug;

    localparam int n_rows = 14;

    // command word, beats on rdata and wdata, random ready flag, expected status
    localparam logic [31:0] tbl_cmd [n_rows] = '{
        32'h0000_0000, 32'h0000_0001, 32'h0000_0002, 32'h0000_0013, 32'h0000_0014,
        32'h0000_0005, 32'h0000_0015, 32'h0000_0013, 32'hbeef_0007, 32'h1234_0007,
        32'h0000_0000, 32'h0000_0006, 32'h0000_0014, 32'h0000_0016};
    localparam int tbl_n_rd [n_rows] = '{6, 3, 0, 2, 2, 0, 6, 4, 0, 3, 0, 2, 0, 2};
    localparam int tbl_n_wr [n_rows] = '{6, 6, 2, 5, 3, 0, 6, 6, 0, 0, 0, 2, 0, 2};
    localparam bit tbl_rnd [n_rows] = '{1, 1, 1, 1, 0, 0, 1, 1, 0, 1, 0, 1, 0, 1};
    localparam logic [31:0] tbl_status [n_rows] = '{
        32'h00, 32'h01, 32'h00, 32'h20, 32'h00, 32'h04, 32'h44, 32'h64, 32'h6c, 32'h6c,
        32'h64, 32'h60, 32'h40, 32'h00};

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [`CMD_W-1:0] wb_dat_w;
    logic wb_ack;
    logic [`CMD_W-1:0] wb_dat_r;
    logic [`DATA_W-1:0] rd_in_data;
    logic rd_in_valid;
    logic rd_in_ready;
    logic [`DATA_W-1:0] rd_out_data;
    logic rd_out_valid;
    logic rd_out_ready;
    logic [`DATA_W-1:0] wr_in_data;
    logic wr_in_valid;
    logic wr_in_ready;
    logic [`DATA_W-1:0] wr_out_data;
    logic wr_out_valid;
    logic wr_out_ready;
    logic [`DATA_W-1:0] log_data;
    chan_pkg::chan_e log_chan;
    logic log_valid;
    logic log_ready;

    logic [15:0] lfsr;
    logic streaming;
    logic rnd_mode;
    int tx_req [2];
    int tx_sent [2];
    int errors;
    int checks;
    int cycles;
    int cycle_limit;

    // reference model of the governor state
    logic m_pause [2];
    logic m_drop [2];
    logic m_log [2];
    logic m_inj [2];
    logic [`DATA_W-1:0] m_inj_data [2];
    logic [`DATA_W-1:0] out_q_rd [$];
    logic [`DATA_W-1:0] out_q_wr [$];
    logic [`DATA_W-1:0] log_q_rd [$];
    logic [`DATA_W-1:0] log_q_wr [$];

    axis_debug_top i_axis_debug_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [`DATA_W-1:0] rand_word();
        logic [`DATA_W-1:0] w;
        for (int i = 0; i < `DATA_W; i++) begin
            w[i] = rand_bit();
        end
        return w;
    endfunction

    function automatic int out_size(input int ch);
        return (ch == 0) ? out_q_rd.size() : out_q_wr.size();
    endfunction

    function automatic int log_size(input int ch);
        return (ch == 0) ? log_q_rd.size() : log_q_wr.size();
    endfunction

    function automatic logic [`DATA_W-1:0] pop_out(input int ch);
        return (ch == 0) ? out_q_rd.pop_front() : out_q_wr.pop_front();
    endfunction

    function automatic logic [`DATA_W-1:0] pop_log(input int ch);
        return (ch == 0) ? log_q_rd.pop_front() : log_q_wr.pop_front();
    endfunction

    function automatic void apply_cmd(input logic [`CMD_W-1:0] c);
        cmd_pkg::cmd_op_e op;
        int ch;
        op = cmd_pkg::cmd_op_e'(c[`OP_MSB:`OP_LSB]);
        ch = int'(c[`CHAN_BIT]);
        case (op)
            cmd_pkg::op_pause:   m_pause[ch] = 1'b1;
            cmd_pkg::op_unpause: m_pause[ch] = 1'b0;
            cmd_pkg::op_drop:    m_drop[ch] = 1'b1;
            cmd_pkg::op_undrop:  m_drop[ch] = 1'b0;
            cmd_pkg::op_log_on:  m_log[ch] = 1'b1;
            cmd_pkg::op_log_off: m_log[ch] = 1'b0;
            cmd_pkg::op_inject: begin
                // a pending injection keeps its payload
                if (!m_inj[ch]) begin
                    m_inj[ch] = 1'b1;
                    m_inj_data[ch] = {{(`DATA_W - 16){1'b0}}, c[`PAYLOAD_MSB:`PAYLOAD_LSB]};
                end
            end
            default: begin
            end
        endcase
    endfunction

    // one channel's handshakes against the model
    task automatic watch_chan(input int ch, input logic iv, input logic ir,
                              input logic [`DATA_W-1:0] id, input logic ov,
                              input logic ordy, input logic [`DATA_W-1:0] od);
        logic [`DATA_W-1:0] exp;
        string nm;
        nm = (ch == 0) ? "rd" : "wr";
        if (iv && ir) begin
            if (!m_drop[ch]) begin
                if (ch == 0) out_q_rd.push_back(id);
                else out_q_wr.push_back(id);
            end
            if (m_log[ch]) begin
                if (ch == 0) log_q_rd.push_back(id);
                else log_q_wr.push_back(id);
            end
        end
        checks++;
        if (m_inj[ch]) begin
            assert (!ir && ov) else begin
                $display("%s channel does not offer the injected beat alone at %0t", nm, $time);
                errors++;
            end
        end else if (m_pause[ch]) begin
            assert (!ov && !ir) else begin
                $display("%s channel moved while paused at %0t", nm, $time);
                errors++;
            end
        end else if (m_drop[ch]) begin
            assert (!ov) else begin
                $display("ERR %0t %s_out_valid exp 0 got %b", $time, nm, ov);
                errors++;
            end
        end
        if (ov && ordy) begin
            if (m_inj[ch]) begin
                exp = m_inj_data[ch];
                m_inj[ch] = 1'b0;
            end else if (out_size(ch) > 0) begin
                exp = pop_out(ch);
            end else begin
                exp = 'x;
                $display("%s output gave a beat that was never sent at %0t", nm, $time);
                errors++;
            end
            assert (od === exp) else begin
                $display("ERR %0t %s_out_data exp %h got %h", $time, nm, exp, od);
                errors++;
            end
        end
    endtask

    function automatic logic chan_idle(input int ch, input logic iv);
        return m_pause[ch] ||
               (tx_req[ch] == tx_sent[ch] && !iv && out_size(ch) == 0 && !m_inj[ch]);
    endfunction

    task automatic wb_xfer(input logic we, input logic [`CMD_W-1:0] d,
                           input logic [`CMD_W-1:0] exp_r);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_dat_w <= d;
        @(posedge clk);
        assert (!wb_ack) else begin
            $display("wb_ack raised before the request was sampled at %0t", $time);
            errors++;
        end
        @(posedge clk);
        assert (wb_ack) else begin
            $display("wb_ack missing one edge after the request at %0t", $time);
            errors++;
        end
        if (!we) begin
            assert (wb_dat_r === exp_r) else begin
                $display("ERR %0t wb_dat_r exp %h got %h", $time, exp_r, wb_dat_r);
                errors++;
            end
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(posedge clk);
        assert (!wb_ack) else begin
            $display("wb_ack held longer than one cycle at %0t", $time);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus, monitor and timeout
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            if (!rd_in_valid || rd_in_ready) begin
                if (tx_req[0] > tx_sent[0]) begin
                    rd_in_data <= rand_word();
                    rd_in_valid <= 1'b1;
                    tx_sent[0] <= tx_sent[0] + 1;
                end else begin
                    rd_in_valid <= 1'b0;
                end
            end
            if (!wr_in_valid || wr_in_ready) begin
                if (tx_req[1] > tx_sent[1]) begin
                    wr_in_data <= rand_word();
                    wr_in_valid <= 1'b1;
                    tx_sent[1] <= tx_sent[1] + 1;
                end else begin
                    wr_in_valid <= 1'b0;
                end
            end
            rd_out_ready <= streaming && (!rnd_mode || rand_bit());
            wr_out_ready <= streaming && (!rnd_mode || rand_bit());
            log_ready <= !rnd_mode || rand_bit();
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            // commands act on the edge that raised ack
            if (wb_ack && wb_we) begin
                apply_cmd(wb_dat_w);
            end
            watch_chan(0, rd_in_valid, rd_in_ready, rd_in_data, rd_out_valid, rd_out_ready,
                       rd_out_data);
            watch_chan(1, wr_in_valid, wr_in_ready, wr_in_data, wr_out_valid, wr_out_ready,
                       wr_out_data);
            if (log_valid) begin
                assert (log_size(int'(log_chan)) > 0) else begin
                    $display("log offers a beat that was never logged at %0t", $time);
                    errors++;
                end
                if (log_ready && log_size(int'(log_chan)) > 0) begin
                    logic [`DATA_W-1:0] exp_log;
                    exp_log = pop_log(int'(log_chan));
                    assert (log_data === exp_log) else begin
                        $display("ERR %0t log_data exp %h got %h", $time, exp_log, log_data);
                        errors++;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, streams did not drain", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        lfsr = 16'd23307;
        rst = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_dat_w = '0;
        rd_in_data = '0;
        rd_in_valid = 1'b0;
        rd_out_ready = 1'b0;
        wr_in_data = '0;
        wr_in_valid = 1'b0;
        wr_out_ready = 1'b0;
        log_ready = 1'b0;
        streaming = 1'b0;
        rnd_mode = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        total = 0;
        for (int c = 0; c < 2; c++) begin
            tx_req[c] = 0;
            tx_sent[c] = 0;
            m_pause[c] = 1'b0;
            m_drop[c] = 1'b0;
            m_log[c] = 1'b0;
            m_inj[c] = 1'b0;
            m_inj_data[c] = '0;
        end
        for (int r = 0; r < n_rows; r++) begin
            total += tbl_n_rd[r] + tbl_n_wr[r];
        end
        cycle_limit = total * 20 + 500;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        for (int r = 0; r < n_rows; r++) begin
            wb_xfer(1'b1, tbl_cmd[r], '0);
            wb_xfer(1'b0, '0, tbl_status[r]);
            checks++;
            rnd_mode <= tbl_rnd[r];
            // a row without beats keeps the outputs held, so an injection stays pending
            if (tbl_n_rd[r] + tbl_n_wr[r] > 0) begin
                streaming <= 1'b1;
                tx_req[0] <= tx_req[0] + tbl_n_rd[r];
                tx_req[1] <= tx_req[1] + tbl_n_wr[r];
                @(posedge clk);
                while (!(chan_idle(0, rd_in_valid) && chan_idle(1, wr_in_valid) &&
                         log_size(0) == 0 && log_size(1) == 0)) begin
                    @(posedge clk);
                end
                // hold outputs back while the next command lands
                streaming <= 1'b0;
                repeat (2) @(posedge clk);
            end
        end
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/axis_debug_top.sv
`timescale 1ns/10ps
`include "dbg_defs.svh"

module axis_debug_top (
    input  logic               clk,
    input  logic               rst,
    // wishbone command port
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [`CMD_W-1:0]  wb_dat_w,
    output logic               wb_ack,
    output logic [`CMD_W-1:0]  wb_dat_r,
    // rdata stream
    input  logic [`DATA_W-1:0] rd_in_data,
    input  logic               rd_in_valid,
    output logic               rd_in_ready,
    output logic [`DATA_W-1:0] rd_out_data,
    output logic               rd_out_valid,
    input  logic               rd_out_ready,
    // wdata stream
    input  logic [`DATA_W-1:0] wr_in_data,
    input  logic               wr_in_valid,
    output logic               wr_in_ready,
    output logic [`DATA_W-1:0] wr_out_data,
    output logic               wr_out_valid,
    input  logic               wr_out_ready,
    // shared log stream
    output logic [`DATA_W-1:0] log_data,
    output chan_pkg::chan_e    log_chan,
    output logic               log_valid,
    input  logic               log_ready
);

    logic [1:0]         pause;
    logic [1:0]         drop;
    logic [1:0]         log_en;
    logic [1:0]         inj_valid;
    logic [1:0]         inj_done;
    logic [`DATA_W-1:0] inj_data_rd;
    logic [`DATA_W-1:0] inj_data_wr;
    logic [1:0]         lbuf_valid;
    logic [1:0]         lbuf_ready;
    logic [`DATA_W-1:0] lbuf_data_rd;
    logic [`DATA_W-1:0] lbuf_data_wr;

    cmd_regs u_cmd (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_dat_w    (wb_dat_w),
        .inj_done    (inj_done),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .pause       (pause),
        .drop        (drop),
        .log_en      (log_en),
        .inj_valid   (inj_valid),
        .inj_data_rd (inj_data_rd),
        .inj_data_wr (inj_data_wr)
    );

    stream_governor u_gov_rd (
        .clk        (clk),
        .rst        (rst),
        .in_data    (rd_in_data),
        .in_valid   (rd_in_valid),
        .in_ready   (rd_in_ready),
        .out_data   (rd_out_data),
        .out_valid  (rd_out_valid),
        .out_ready  (rd_out_ready),
        .pause      (pause[chan_pkg::chan_rdata]),
        .drop       (drop[chan_pkg::chan_rdata]),
        .log_en     (log_en[chan_pkg::chan_rdata]),
        .inj_valid  (inj_valid[chan_pkg::chan_rdata]),
        .inj_data   (inj_data_rd),
        .inj_done   (inj_done[chan_pkg::chan_rdata]),
        .lbuf_data  (lbuf_data_rd),
        .lbuf_valid (lbuf_valid[chan_pkg::chan_rdata]),
        .lbuf_ready (lbuf_ready[chan_pkg::chan_rdata])
    );

    stream_governor u_gov_wr (
        .clk        (clk),
        .rst        (rst),
        .in_data    (wr_in_data),
        .in_valid   (wr_in_valid),
        .in_ready   (wr_in_ready),
        .out_data   (wr_out_data),
        .out_valid  (wr_out_valid),
        .out_ready  (wr_out_ready),
        .pause      (pause[chan_pkg::chan_wdata]),
        .drop       (drop[chan_pkg::chan_wdata]),
        .log_en     (log_en[chan_pkg::chan_wdata]),
        .inj_valid  (inj_valid[chan_pkg::chan_wdata]),
        .inj_data   (inj_data_wr),
        .inj_done   (inj_done[chan_pkg::chan_wdata]),
        .lbuf_data  (lbuf_data_wr),
        .lbuf_valid (lbuf_valid[chan_pkg::chan_wdata]),
        .lbuf_ready (lbuf_ready[chan_pkg::chan_wdata])
    );

    log_arbiter u_log_arb (
        .clk          (clk),
        .rst          (rst),
        .lbuf_valid   (lbuf_valid),
        .lbuf_data_rd (lbuf_data_rd),
        .lbuf_data_wr (lbuf_data_wr),
        .lbuf_ready   (lbuf_ready),
        .log_data     (log_data),
        .log_chan     (log_chan),
        .log_valid    (log_valid),
        .log_ready    (log_ready)
    );

endmodule

// File: rtl/log_arbiter.sv
`timescale 1ns/10ps
`include "dbg_defs.svh"

module log_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         lbuf_valid,
    input  logic [`DATA_W-1:0] lbuf_data_rd,
    input  logic [`DATA_W-1:0] lbuf_data_wr,
    output logic [1:0]         lbuf_ready,
    output logic [`DATA_W-1:0] log_data,
    output chan_pkg::chan_e    log_chan,
    output logic               log_valid,
    input  logic               log_ready
);

    chan_pkg::chan_e prio;
    chan_pkg::chan_e hold_chan;
    chan_pkg::chan_e grant;
    logic            hold;

    // locked grant wins, otherwise favor prio on a tie
    always_comb begin
        if (hold) begin
            grant = hold_chan;
        end else if (lbuf_valid[prio]) begin
            grant = prio;
        end else begin
            grant = chan_pkg::chan_e'(~prio);
        end
    end

    assign log_valid = lbuf_valid[grant];
    assign log_chan  = grant;
    assign log_data  = (grant == chan_pkg::chan_rdata) ? lbuf_data_rd : lbuf_data_wr;

    always_comb begin
        lbuf_ready        = 2'b00;
        lbuf_ready[grant] = log_valid && log_ready;
    end

    // keep the offer stable under back-pressure
    always_ff @(posedge clk) begin
        if (!rst) begin
            hold      <= 1'b0;
            hold_chan <= chan_pkg::chan_rdata;
            prio      <= chan_pkg::chan_rdata;
        end else if (log_valid && log_ready) begin
            hold <= 1'b0;
            prio <= chan_pkg::chan_e'(~grant);
        end else if (log_valid) begin
            hold      <= 1'b1;
            hold_chan <= grant;
        end
    end

endmodule

// File: rtl/stream_governor.sv
`timescale 1ns/10ps
`include "dbg_defs.svh"

module stream_governor (
    input  logic               clk,
    input  logic               rst,
    input  logic [`DATA_W-1:0] in_data,
    input  logic               in_valid,
    output logic               in_ready,
    output logic [`DATA_W-1:0] out_data,
    output logic               out_valid,
    input  logic               out_ready,
    input  logic               pause,
    input  logic               drop,
    input  logic               log_en,
    input  logic               inj_valid,
    input  logic [`DATA_W-1:0] inj_data,
    output logic               inj_done,
    output logic [`DATA_W-1:0] lbuf_data,
    output logic               lbuf_valid,
    input  logic               lbuf_ready
);

    logic log_space;
    logic accept;

    // logging needs an empty buffer before taking another beat
    assign log_space = !log_en || !lbuf_valid;
    assign accept    = in_valid && in_ready;

    ////////////////////////////////////////////////////////////
    // handshake priority: inject, pause, drop, pass
    ////////////////////////////////////////////////////////////

    always_comb begin
        out_data  = in_data;
        out_valid = 1'b0;
        in_ready  = 1'b0;
        inj_done  = 1'b0;
        if (inj_valid) begin
            // injected beat offered until the output takes it
            out_data  = inj_data;
            out_valid = 1'b1;
            inj_done  = out_ready;
        end else if (pause) begin
            out_valid = 1'b0;
            in_ready  = 1'b0;
        end else if (drop) begin
            // swallow input, only the log can hold us back
            in_ready = log_space;
        end else begin
            // gate both sides on log space so transfers stay paired
            out_valid = in_valid && log_space;
            in_ready  = out_ready && log_space;
        end
    end

    ////////////////////////////////////////////////////////////
    // one-beat log buffer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            lbuf_valid <= 1'b0;
        end else if (accept && log_en) begin
            lbuf_valid <= 1'b1;
        end else if (lbuf_ready) begin
            lbuf_valid <= 1'b0;
        end
    end

    // capture covers dropped beats too, never injected ones
    always_ff @(posedge clk) begin
        if (accept && log_en) begin
            lbuf_data <= in_data;
        end
    end

endmodule

// File: rtl/cmd_regs.sv
`timescale 1ns/10ps
`include "dbg_defs.svh"

module cmd_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [`CMD_W-1:0]  wb_dat_w,
    input  logic [1:0]         inj_done,
    output logic               wb_ack,
    output logic [`CMD_W-1:0]  wb_dat_r,
    output logic [1:0]         pause,
    output logic [1:0]         drop,
    output logic [1:0]         log_en,
    output logic [1:0]         inj_valid,
    output logic [`DATA_W-1:0] inj_data_rd,
    output logic [`DATA_W-1:0] inj_data_wr
);

    localparam int PAY_W = `PAYLOAD_MSB - `PAYLOAD_LSB + 1;

    cmd_pkg::wb_state_e wb_state;
    cmd_pkg::cmd_op_e   op;
    chan_pkg::chan_e    chan;
    logic               wr_req;
    logic               inj_take;
    logic [PAY_W-1:0]   payload;
    logic [`DATA_W-1:0] inj_data_q [2];

    ////////////////////////////////////////////////////////////
    // command decode
    ////////////////////////////////////////////////////////////

    assign op      = cmd_pkg::cmd_op_e'(wb_dat_w[`OP_MSB:`OP_LSB]);
    assign chan    = chan_pkg::chan_e'(wb_dat_w[`CHAN_BIT]);
    assign payload = wb_dat_w[`PAYLOAD_MSB:`PAYLOAD_LSB];

    // write acts on the same edge that raises ack
    assign wr_req   = (wb_state == cmd_pkg::wb_idle) && wb_cyc && wb_stb && wb_we;
    // a second inject while one is pending is ignored
    assign inj_take = wr_req && (op == cmd_pkg::op_inject) && !inj_valid[chan];

    // one-cycle ack, then back to idle
    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_state <= cmd_pkg::wb_idle;
        end else begin
            case (wb_state)
                cmd_pkg::wb_idle: begin
                    if (wb_cyc && wb_stb) begin
                        wb_state <= cmd_pkg::wb_ack;
                    end
                end
                default: begin
                    wb_state <= cmd_pkg::wb_idle;
                end
            endcase
        end
    end

    assign wb_ack = (wb_state == cmd_pkg::wb_ack);

    ////////////////////////////////////////////////////////////
    // per-channel enables
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            pause     <= 2'b00;
            drop      <= 2'b00;
            log_en    <= 2'b00;
            inj_valid <= 2'b00;
        end else begin
            // retire injection once the governor reports the transfer
            inj_valid <= inj_valid & ~inj_done;
            if (wr_req) begin
                case (op)
                    cmd_pkg::op_pause:   pause[chan]  <= 1'b1;
                    cmd_pkg::op_unpause: pause[chan]  <= 1'b0;
                    cmd_pkg::op_drop:    drop[chan]   <= 1'b1;
                    cmd_pkg::op_undrop:  drop[chan]   <= 1'b0;
                    cmd_pkg::op_log_on:  log_en[chan] <= 1'b1;
                    cmd_pkg::op_log_off: log_en[chan] <= 1'b0;
                    cmd_pkg::op_inject: begin
                        if (inj_take) begin
                            inj_valid[chan] <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // injected payload, zero-extended
    always_ff @(posedge clk) begin
        if (inj_take) begin
            inj_data_q[chan] <= {{(`DATA_W - PAY_W){1'b0}}, payload};
        end
    end

    assign inj_data_rd = inj_data_q[chan_pkg::chan_rdata];
    assign inj_data_wr = inj_data_q[chan_pkg::chan_wdata];

    // status word from the live enables
    always_comb begin
        wb_dat_r = '0;
        for (int c = 0; c < 2; c++) begin
            wb_dat_r[c*`ST_CHAN_STRIDE + `ST_PAUSE] = pause[c];
            wb_dat_r[c*`ST_CHAN_STRIDE + `ST_DROP]  = drop[c];
            wb_dat_r[c*`ST_CHAN_STRIDE + `ST_LOG]   = log_en[c];
            wb_dat_r[c*`ST_CHAN_STRIDE + `ST_INJ]   = inj_valid[c];
        end
    end

endmodule

// File: rtl/chan_pkg.sv
package chan_pkg;

    // stream channel select, also the log tag
    typedef enum logic {
        chan_rdata = 1'b0,
        chan_wdata = 1'b1
    } chan_e;

endpackage

// File: rtl/cmd_pkg.sv
package cmd_pkg;

    // host command opcodes, unlisted codes behave as nop
    typedef enum logic [3:0] {
        op_nop     = 4'd0,
        op_pause   = 4'd1,
        op_unpause = 4'd2,
        op_drop    = 4'd3,
        op_undrop  = 4'd4,
        op_log_on  = 4'd5,
        op_log_off = 4'd6,
        op_inject  = 4'd7
    } cmd_op_e;

    // wishbone slave handshake
    typedef enum logic {
        wb_idle = 1'b0,
        wb_ack  = 1'b1
    } wb_state_e;

endpackage

// File: rtl/dbg_defs.svh
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// stream and wishbone widths
`define DATA_W          32
`define CMD_W           32

// command word fields
`define OP_LSB          0
`define OP_MSB          3
`define CHAN_BIT        4
`define PAYLOAD_LSB     16
`define PAYLOAD_MSB     31

// status nibble, one per channel
`define ST_PAUSE        0
`define ST_DROP         1
`define ST_LOG          2
`define ST_INJ          3
`define ST_CHAN_STRIDE  4

`endif
